//--- rtl/frame_store_defines.svh
// QCIF 4:2:0 geometry only, four 8-bit pixels per 32-bit word; other frame sizes are not supported
`ifndef FRAME_STORE_DEFINES_SVH
`define FRAME_STORE_DEFINES_SVH

// ------------------------------
// Frame size and address width
// ------------------------------
`define FRAME_WORDS 9504
`define FRAME_AW 14

// Macroblock grid, 11 x 9
`define MB_COLS 11
`define MB_COUNT 99

// ------------------------------
// Plane strides and bases, in words
// ------------------------------
`define LUMA_STRIDE 44
`define CHROMA_STRIDE 22
`define CB_BASE 6336
`define CR_BASE 7920

`endif

//--- rtl/frame_layout_pkg.sv
// Position fields assume 16x16 luma and 8x8 chroma blocks; chroma row must stay below 8, word below 2
`default_nettype none

package frame_layout_pkg;

	// ------------------------------
	// Plane selector
	// ------------------------------

	// Encoding 2'b11 is unused
	typedef enum logic [1:0]
	{
		luma = 2'd0,
		cb   = 2'd1,
		cr   = 2'd2
	} plane_t;

	// ------------------------------
	// Word position inside a macroblock
	// ------------------------------

	// mb_num counts in raster order, 0 to 98
	// row is the pixel row inside the block
	// word picks the 4-pixel group inside the row
	typedef struct packed
	{
		logic [6:0] mb_num;
		plane_t     plane;
		logic [3:0] row;
		logic [1:0] word;
	} mb_pos_t;

	// Luma block spans 16 rows of 4 words
	localparam int luma_block_rows = 16;
	localparam int luma_block_words = 4;

	// Chroma block spans 8 rows of 2 words
	localparam int chroma_block_rows = 8;
	localparam int chroma_block_words = 2;

endpackage

`default_nettype wire

//--- rtl/frame_bus_pkg.sv
// Bus payloads carry one 32-bit word per beat; address width follows the frame defines
`default_nettype none

`include "frame_store_defines.svh"

package frame_bus_pkg;

	// ------------------------------
	// Writer side
	// ------------------------------

	// One-cycle strobe, no back-pressure
	typedef struct packed
	{
		logic                       valid;
		frame_layout_pkg::mb_pos_t  pos;
		logic [31:0]                data;
	} mb_write_t;

	// ------------------------------
	// RAM port and readout
	// ------------------------------

	// Active-high chip select, wr high for a write
	typedef struct packed
	{
		logic                 cs;
		logic                 wr;
		logic [`FRAME_AW-1:0] addr;
		logic [31:0]          data;
	} ram_cmd_t;

	// One beat per frame word during a scan
	typedef struct packed
	{
		logic                 valid;
		logic [`FRAME_AW-1:0] addr;
		logic [31:0]          data;
	} scan_beat_t;

endpackage

`default_nettype wire

//--- rtl/mb_addr_decode.sv
// Expects in-range positions (mb_num < 99, chroma row < 8 and word < 2); output lags request by one cycle
`timescale 1ns/1ps
`default_nettype none

`include "frame_store_defines.svh"

module mb_addr_decode
(
	input  wire logic                    clk,
	input  wire logic                    reset_n,
	input  wire frame_bus_pkg::mb_write_t wr_req,
	output frame_bus_pkg::ram_cmd_t      wr_cmd
);

	typedef logic [`FRAME_AW-1:0] addr_t;

	// One macroblock row covers 16 luma rows or 8 chroma rows
	localparam int luma_mb_row_step = frame_layout_pkg::luma_block_rows * `LUMA_STRIDE;
	localparam int chroma_mb_row_step = frame_layout_pkg::chroma_block_rows * `CHROMA_STRIDE;

	logic [3:0] mb_row;
	logic [3:0] mb_col;
	addr_t      plane_base;
	addr_t      mb_offset;
	addr_t      row_offset;
	addr_t      lin_addr;

	// ------------------------------
	// Position to linear address
	// ------------------------------
	always_comb
	begin
		mb_row = 4'(wr_req.pos.mb_num / `MB_COLS);
		mb_col = 4'(wr_req.pos.mb_num % `MB_COLS);
		if (wr_req.pos.plane == frame_layout_pkg::luma)
		begin
			plane_base = '0;
			mb_offset  = addr_t'(mb_row * luma_mb_row_step +
				mb_col * frame_layout_pkg::luma_block_words);
			row_offset = addr_t'(wr_req.pos.row * `LUMA_STRIDE);
		end
		else
		begin
			// Cb and Cr share the chroma layout, only the base differs
			plane_base = (wr_req.pos.plane == frame_layout_pkg::cr) ? addr_t'(`CR_BASE) :
				addr_t'(`CB_BASE);
			mb_offset  = addr_t'(mb_row * chroma_mb_row_step +
				mb_col * frame_layout_pkg::chroma_block_words);
			row_offset = addr_t'(wr_req.pos.row * `CHROMA_STRIDE);
		end
		lin_addr = plane_base + mb_offset + row_offset + addr_t'(wr_req.pos.word);
	end

	// Register the write command with its data
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			wr_cmd.cs <= 1'b0;
			wr_cmd.wr <= 1'b0;
		end
		else
		begin
			wr_cmd.cs <= wr_req.valid;
			wr_cmd.wr <= wr_req.valid;
		end
		wr_cmd.addr <= lin_addr;
		wr_cmd.data <= wr_req.data;
	end

	// Writer must stay inside the macroblock grid
	a_mb_num_range: assert property (@(posedge clk) disable iff (!reset_n)
		wr_req.valid |-> wr_req.pos.mb_num < `MB_COUNT);

	a_chroma_range: assert property (@(posedge clk) disable iff (!reset_n)
		(wr_req.valid && wr_req.pos.plane != frame_layout_pkg::luma) |->
		(wr_req.pos.row < 4'd8 && wr_req.pos.word < 2'd2));

endmodule

`default_nettype wire

//--- rtl/ext_frame_ram.sv
// Single port, one access per cycle; read data appears one cycle after a read and holds otherwise
`timescale 1ns/1ps
`default_nettype none

`include "frame_store_defines.svh"

module ext_frame_ram
(
	input  wire logic                   clk,
	input  wire frame_bus_pkg::ram_cmd_t cmd,
	output logic [31:0]                 rd_data
);

	// ------------------------------
	// Storage
	// ------------------------------

	// Powers up as an all-zero frame
	logic [31:0] mem [0:`FRAME_WORDS-1] = '{default: '0};

	logic do_write;
	logic do_read;

	assign do_write = cmd.cs && cmd.wr;
	assign do_read  = cmd.cs && !cmd.wr;

	// Sync write
	always_ff @(posedge clk)
	begin
		if (do_write)
		begin
			mem[cmd.addr] <= cmd.data;
		end
	end

	// Sync read, old data on a read of a word being written is not possible
	// since the port takes one command per cycle
	always_ff @(posedge clk)
	begin
		if (do_read)
		begin
			rd_data <= mem[cmd.addr];
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------

	// Both the decoder and the scanner must keep addresses inside the frame
	a_addr_range: assert property (@(posedge clk)
		cmd.cs |-> cmd.addr < `FRAME_WORDS);

endmodule

`default_nettype wire

//--- rtl/display_scan.sv
// Writes always take the port and stall the scan; start pulses during a scan are ignored
`timescale 1ns/1ps
`default_nettype none

`include "frame_store_defines.svh"

module display_scan
(
	input  wire logic                   clk,
	input  wire logic                   reset_n,
	input  wire logic                   scan_start,
	input  wire frame_bus_pkg::ram_cmd_t wr_cmd,
	output frame_bus_pkg::ram_cmd_t     ram_cmd,
	input  wire logic [31:0]            rd_data,
	output frame_bus_pkg::scan_beat_t   scan_beat,
	output logic                        scan_done
);

	localparam logic [`FRAME_AW-1:0] last_addr = `FRAME_AW'(`FRAME_WORDS - 1);

	logic                 busy;
	logic [`FRAME_AW-1:0] scan_addr;
	logic                 issue_rd;
	logic                 rd_pend;
	logic [`FRAME_AW-1:0] rd_addr;

	// ------------------------------
	// Port arbitration
	// ------------------------------

	// A pending write blocks the read for this cycle
	assign issue_rd = busy && !wr_cmd.cs;

	always_comb
	begin
		if (wr_cmd.cs)
		begin
			ram_cmd = wr_cmd;
		end
		else
		begin
			ram_cmd.cs   = issue_rd;
			ram_cmd.wr   = 1'b0;
			ram_cmd.addr = scan_addr;
			ram_cmd.data = '0;
		end
	end

	// ------------------------------
	// Scan sequencer
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			busy      <= 1'b0;
			scan_addr <= '0;
			rd_pend   <= 1'b0;
		end
		else
		begin
			rd_pend <= issue_rd;
			if (issue_rd)
			begin
				// Address only advances when the read went out
				if (scan_addr == last_addr)
				begin
					busy      <= 1'b0;
					scan_addr <= '0;
				end
				else
				begin
					scan_addr <= scan_addr + 1'b1;
				end
			end
			else if (scan_start && !busy)
			begin
				busy      <= 1'b1;
				scan_addr <= '0;
			end
		end
		rd_addr <= scan_addr;
	end

	// RAM data lands one cycle after the read
	assign scan_beat.valid = rd_pend;
	assign scan_beat.addr  = rd_addr;
	assign scan_beat.data  = rd_data;
	assign scan_done       = rd_pend && (rd_addr == last_addr);

	// Write cycles hold the scan address and send no read
	a_no_read_on_write: assert property (@(posedge clk) disable iff (!reset_n)
		wr_cmd.cs |=> (!rd_pend && scan_addr == $past(scan_addr)));

endmodule

`default_nettype wire

//--- rtl/frame_store_top.sv
// One QCIF frame, single buffer; scan length grows by one cycle per write issued during it
`timescale 1ns/1ps
`default_nettype none

module frame_store_top
(
	input  wire logic                    clk,
	input  wire logic                    reset_n,
	input  wire frame_bus_pkg::mb_write_t wr_req,
	input  wire logic                    scan_start,
	output frame_bus_pkg::scan_beat_t    scan_beat,
	output logic                         scan_done
);

	frame_bus_pkg::ram_cmd_t wr_cmd;
	frame_bus_pkg::ram_cmd_t ram_cmd;
	logic [31:0]             rd_data;

	// ------------------------------
	// Write path
	// ------------------------------
	mb_addr_decode i_mb_addr_decode
	(
		.clk     (clk),
		.reset_n (reset_n),
		.wr_req  (wr_req),
		.wr_cmd  (wr_cmd)
	);

	// Scanner owns the RAM port
	display_scan i_display_scan
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.scan_start (scan_start),
		.wr_cmd     (wr_cmd),
		.ram_cmd    (ram_cmd),
		.rd_data    (rd_data),
		.scan_beat  (scan_beat),
		.scan_done  (scan_done)
	);

	ext_frame_ram i_ext_frame_ram
	(
		.clk     (clk),
		.cmd     (ram_cmd),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

//--- verification/frame_store_tb.sv
// Needs rtl/ on the include path; all RAM writes come from this bench, model starts as a zero frame
`timescale 1ns/1ps
`default_nettype none

`include "frame_store_defines.svh"

module frame_store_tb;

	localparam int n_preload = 1500;
	// Two scans, the second stretched by up to one stall per write, plus preload
	localparam int cycle_limit = 40000;

	logic                      clk;
	logic                      reset_n;
	frame_bus_pkg::mb_write_t  wr_req;
	logic                      scan_start;
	frame_bus_pkg::scan_beat_t scan_beat;
	logic                      scan_done;

	logic [31:0] model [0:`FRAME_WORDS-1];
	logic [31:0] rng_state = 32'hb469_3bbb;
	int          errors = 0;
	int          beat_count = 0;
	int          done_count = 0;
	int          exp_addr = 0;
	int          cycles = 0;
	int          stall_writes = 0;
	int          plane_hits [0:2];

	frame_store_top i_frame_store_top
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.wr_req     (wr_req),
		.scan_start (scan_start),
		.scan_beat  (scan_beat),
		.scan_done  (scan_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// Stimulus helpers
	// ------------------------------
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Linear address of a macroblock word, from the frame layout
	function automatic int frame_addr(input frame_layout_pkg::mb_pos_t pos);
		int mb_row;
		int mb_col;
		int base;
		mb_row = int'(pos.mb_num) / `MB_COLS;
		mb_col = int'(pos.mb_num) % `MB_COLS;
		if (pos.plane == frame_layout_pkg::luma)
		begin
			return mb_row * 16 * `LUMA_STRIDE + mb_col * 4 + int'(pos.row) * `LUMA_STRIDE +
				int'(pos.word);
		end
		base = (pos.plane == frame_layout_pkg::cb) ? `CB_BASE : `CR_BASE;
		return base + mb_row * 8 * `CHROMA_STRIDE + mb_col * 2 +
			int'(pos.row) * `CHROMA_STRIDE + int'(pos.word);
	endfunction

	function automatic frame_layout_pkg::mb_pos_t random_pos();
		frame_layout_pkg::mb_pos_t pos;
		logic [31:0]               r;
		r = next_rand();
		pos.mb_num = 7'((r >> 8) % `MB_COUNT);
		pos.plane  = frame_layout_pkg::plane_t'(2'((r >> 20) % 3));
		if (pos.plane == frame_layout_pkg::luma)
		begin
			pos.row  = r[27:24];
			pos.word = r[29:28];
		end
		else
		begin
			pos.row  = {1'b0, r[26:24]};
			pos.word = {1'b0, r[28]};
		end
		return pos;
	endfunction

	task automatic drive_write(input frame_layout_pkg::mb_pos_t pos, input logic [31:0] data);
		frame_bus_pkg::mb_write_t req;
		req.valid = 1'b1;
		req.pos   = pos;
		req.data  = data;
		@(posedge clk);
		wr_req <= req;
		model[frame_addr(pos)] = data;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		wr_req.valid <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		scan_start <= 1'b1;
		@(posedge clk);
		scan_start <= 1'b0;
	endtask

	// ------------------------------
	// Beat monitor, sampled away from the rising edge
	// ------------------------------
	always @(negedge clk)
	begin
		if (scan_beat.valid)
		begin
			beat_count++;
			if (scan_beat.addr !== `FRAME_AW'(exp_addr))
			begin
				errors++;
				$display("ERR scan_beat.addr expected %h got %h", exp_addr, scan_beat.addr);
			end
			if (scan_beat.data !== model[exp_addr])
			begin
				errors++;
				$display("ERR scan_beat.data expected %h got %h", model[exp_addr],
					scan_beat.data);
			end
			if (scan_done !== (exp_addr == `FRAME_WORDS - 1))
			begin
				errors++;
				$display("ERR scan_done expected %h got %h", exp_addr == `FRAME_WORDS - 1,
					scan_done);
			end
			if (scan_done)
			begin
				done_count++;
			end
			exp_addr = (exp_addr == `FRAME_WORDS - 1) ? 0 : exp_addr + 1;
		end
		else if (scan_done !== 1'b0)
		begin
			errors++;
			$display("ERR scan_done expected %h got %h", 1'b0, scan_done);
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, the scans did not complete", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial
	begin
		frame_layout_pkg::mb_pos_t pos;
		logic [31:0]               r;
		reset_n    = 1'b0;
		wr_req     = '0;
		scan_start = 1'b0;
		plane_hits = '{default: 0};
		for (int a = 0; a < `FRAME_WORDS; a++)
		begin
			model[a] = '0;
		end
		repeat (4) @(posedge clk);
		reset_n <= 1'b1;

		// Quiet outputs before any start
		repeat (10)
		begin
			@(negedge clk);
			if (scan_beat.valid !== 1'b0)
			begin
				errors++;
				$display("ERR scan_beat.valid expected %h got %h", 1'b0, scan_beat.valid);
			end
			if (scan_done !== 1'b0)
			begin
				errors++;
				$display("ERR scan_done expected %h got %h", 1'b0, scan_done);
			end
		end

		// Preload with random positions, then the corners
		for (int i = 0; i < n_preload; i++)
		begin
			pos = random_pos();
			plane_hits[int'(pos.plane)]++;
			drive_write(pos, next_rand());
		end
		for (int k = 0; k < 2; k++)
		begin
			for (int p = 0; p < 3; p++)
			begin
				pos.mb_num = (k == 0) ? 7'd0 : 7'd98;
				pos.plane  = frame_layout_pkg::plane_t'(2'(p));
				pos.row    = (p == 0) ? 4'd15 : 4'd7;
				pos.word   = (p == 0) ? 2'd3 : 2'd1;
				drive_write(pos, next_rand());
				pos.row  = 4'd0;
				pos.word = 2'd0;
				drive_write(pos, next_rand());
			end
		end
		drive_idle();
		repeat (4) @(posedge clk);
		if (plane_hits[0] == 0 || plane_hits[1] == 0 || plane_hits[2] == 0)
		begin
			errors++;
			$display("Random preload missed at least one plane");
		end
		pos = '{mb_num: 7'd98, plane: frame_layout_pkg::cr, row: 4'd7, word: 2'd1};
		if (frame_addr(pos) != `FRAME_WORDS - 1)
		begin
			errors++;
			$display("Last Cr word of macroblock 98 does not map to the last frame word");
		end

		// First scan, a repeated start in the middle must be ignored
		pulse_start();
		while (beat_count < 100)
		begin
			@(posedge clk);
		end
		pulse_start();
		while (done_count < 1)
		begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);
		if (beat_count != `FRAME_WORDS)
		begin
			errors++;
			$display("ERR beat_count expected %h got %h", `FRAME_WORDS, beat_count);
		end

		// Second scan with writes of the values already held
		pulse_start();
		while (done_count < 2)
		begin
			r = next_rand();
			if (r[31:30] == 2'b00)
			begin
				pos = random_pos();
				stall_writes++;
				drive_write(pos, model[frame_addr(pos)]);
			end
			else
			begin
				drive_idle();
			end
		end
		drive_idle();
		repeat (20) @(posedge clk);
		if (beat_count != 2 * `FRAME_WORDS)
		begin
			errors++;
			$display("ERR beat_count expected %h got %h", 2 * `FRAME_WORDS, beat_count);
		end
		if (stall_writes == 0)
		begin
			errors++;
			$display("No writes were issued during the second scan");
		end

		$display("Summary: %0d beats, %0d scans, %0d stall writes, %0d errors",
			beat_count, done_count, stall_writes, errors);
		if (errors == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+rtl
rtl/frame_layout_pkg.sv
rtl/frame_bus_pkg.sv
rtl/mb_addr_decode.sv
rtl/ext_frame_ram.sv
rtl/display_scan.sv
rtl/frame_store_top.sv
verification/frame_store_tb.sv

//--- Makefile
# Verilator build and self-checking run of the frame store testbench

VERILATOR ?= verilator
TOP       ?= frame_store_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
